//--- compile.f
hdl/rv_isa_pkg.sv
hdl/rv_csr_pkg.sv
hdl/alu.sv
hdl/data_mem.sv
hdl/csr_regs.sv
hdl/exec_unit.sv
hdl/exec_top.sv
tests/exec_top_tb.sv

//--- hdl/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu
  import rv_isa_pkg::*;
(
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  alu_fn_e         fn,
  input  logic            alt,
  output logic [xlen-1:0] val
);

  logic [4:0]      shamt;
  logic            lt_s;
  logic            lt_u;
  logic [xlen-1:0] sum;

  assign shamt = b[4:0]; // only low five bits count
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;
  assign sum   = alt ? (a - b) : (a + b);

  always_comb begin
    case (fn)
      alu_add:  val = sum;
      alu_sll:  val = a << shamt;
      alu_slt:  val = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: val = {{(xlen-1){1'b0}}, lt_u};
      alu_xor:  val = a ^ b;
      alu_srl: begin
        if (alt) begin
          val = $unsigned($signed(a) >>> shamt); // arithmetic
        end else begin
          val = a >> shamt;
        end
      end
      alu_or:   val = a | b;
      alu_and:  val = a & b;
      default:  val = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/csr_regs.sv
`timescale 1ns/10ps
`default_nettype none

module csr_regs
  import rv_isa_pkg::*;
  import rv_csr_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  csr_addr_e       raddr,
  output logic [xlen-1:0] rdata,
  input  logic            wen1,
  input  csr_addr_e       waddr1,
  input  logic [xlen-1:0] wdata1,
  input  logic            wen2,
  input  csr_addr_e       waddr2,
  input  logic [xlen-1:0] wdata2
);

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;

  always_comb begin
    case (raddr)
      csr_mstatus: rdata = mstatus;
      csr_mtvec:   rdata = mtvec;
      csr_mepc:    rdata = mepc;
      csr_mcause:  rdata = mcause;
      default:     rdata = '0; // unimplemented reads zero
    endcase
  end

  // port 2 is written last so it takes priority
  always_ff @(posedge clk) begin
    if (reset) begin
      mstatus <= mstatus_reset;
      mtvec   <= mtvec_reset;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (wen1) begin
        case (waddr1)
          csr_mstatus: mstatus <= wdata1;
          csr_mtvec:   mtvec   <= wdata1;
          csr_mepc:    mepc    <= wdata1;
          csr_mcause:  mcause  <= wdata1;
          default:     ; // dropped
        endcase
      end
      if (wen2) begin
        case (waddr2)
          csr_mstatus: mstatus <= wdata2;
          csr_mtvec:   mtvec   <= wdata2;
          csr_mepc:    mepc    <= wdata2;
          csr_mcause:  mcause  <= wdata2;
          default:     ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem
  import rv_isa_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            rreq_valid,
  input  logic [xlen-1:0] raddr,
  input  mem_fn_e         rfn,
  output logic            rres_valid,
  output logic [xlen-1:0] rdata,
  input  logic            wreq_valid,
  input  logic [xlen-1:0] waddr,
  input  logic [xlen-1:0] wdata,
  input  mem_fn_e         wfn,
  output logic            wres_valid
);

  logic [xlen-1:0]   mem [mem_words];
  logic [mem_aw-1:0] ridx, widx;
  logic [xlen-1:0]   rshift, rext;
  logic [xbytes-1:0] wbe;
  logic [xlen-1:0]   wlane;

  // word index, upper address bits dropped
  assign ridx = raddr[mem_aw+1:2];
  assign widx = waddr[mem_aw+1:2];

  assign rshift = mem[ridx] >> {raddr[1:0], 3'b000};

  always_comb begin
    case (rfn)
      mem_b:   rext = {{(xlen-8){rshift[7]}}, rshift[7:0]};
      mem_bu:  rext = {{(xlen-8){1'b0}}, rshift[7:0]};
      mem_h:   rext = {{(xlen-16){rshift[15]}}, rshift[15:0]};
      mem_hu:  rext = {{(xlen-16){1'b0}}, rshift[15:0]};
      default: rext = rshift;
    endcase
  end

  always_comb begin
    case (wfn)
      mem_b, mem_bu: wbe = xbytes'(1) << waddr[1:0];
      mem_h, mem_hu: wbe = xbytes'(3) << waddr[1:0];
      default:       wbe = '1;
    endcase
  end

  assign wlane = wdata << {waddr[1:0], 3'b000}; // move into its lane

  always_ff @(posedge clk) begin
    if (wreq_valid) begin
      for (int i = 0; i < xbytes; i++) begin
        if (wbe[i]) begin
          mem[widx][8*i +: 8] <= wlane[8*i +: 8];
        end
      end
    end
    if (rreq_valid) begin
      rdata <= rext;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rres_valid <= 1'b0;
      wres_valid <= 1'b0;
    end else begin
      rres_valid <= rreq_valid; // one cycle later
      wres_valid <= wreq_valid;
    end
  end

  function automatic logic aligned(input logic [1:0] lo, input mem_fn_e fn);
    case (fn)
      mem_w:         return lo == 2'b00;
      mem_h, mem_hu: return !lo[0];
      default:       return 1'b1;
    endcase
  endfunction

  a_rd_align: assert property (@(posedge clk) disable iff (reset)
    rreq_valid |-> aligned(raddr[1:0], rfn))
    else $error("misaligned read request");

  a_wr_align: assert property (@(posedge clk) disable iff (reset)
    wreq_valid |-> aligned(waddr[1:0], wfn))
    else $error("misaligned write request");

endmodule

`default_nettype wire

//--- hdl/exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module exec_top
  import rv_isa_pkg::*;
  import rv_csr_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            in_valid,
  output logic            in_ready,
  input  logic [xlen-1:0] pc,
  input  op_class_e       opcode,
  input  logic [2:0]      funct,
  input  logic [4:0]      rd,
  input  logic [xlen-1:0] src1,
  input  logic [xlen-1:0] src2,
  input  logic [xlen-1:0] imm,
  input  logic [xlen-1:0] alu_a,
  input  logic [xlen-1:0] alu_b,
  input  alu_fn_e         alu_fn,
  input  logic            alu_alt,
  output logic [xlen-1:0] npc,
  output logic            gpr_wen,
  output logic [4:0]      gpr_waddr,
  output logic [xlen-1:0] gpr_wdata
);

  // CSR port
  csr_addr_e       csr_raddr;
  logic [xlen-1:0] csr_rdata;
  logic            csr_wen1, csr_wen2;
  csr_addr_e       csr_waddr1, csr_waddr2;
  logic [xlen-1:0] csr_wdata1, csr_wdata2;

  // memory links
  logic            mem_rreq_valid, mem_rres_valid;
  logic [xlen-1:0] mem_raddr, mem_rdata;
  mem_fn_e         mem_rfn;
  logic            mem_wreq_valid, mem_wres_valid;
  logic [xlen-1:0] mem_waddr, mem_wdata;
  mem_fn_e         mem_wfn;

  exec_unit u_exec (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .pc             (pc),
    .opcode         (opcode),
    .funct          (funct),
    .rd             (rd),
    .src1           (src1),
    .src2           (src2),
    .imm            (imm),
    .alu_a          (alu_a),
    .alu_b          (alu_b),
    .alu_fn         (alu_fn),
    .alu_alt        (alu_alt),
    .npc            (npc),
    .gpr_wen        (gpr_wen),
    .gpr_waddr      (gpr_waddr),
    .gpr_wdata      (gpr_wdata),
    .csr_raddr      (csr_raddr),
    .csr_rdata      (csr_rdata),
    .csr_wen1       (csr_wen1),
    .csr_waddr1     (csr_waddr1),
    .csr_wdata1     (csr_wdata1),
    .csr_wen2       (csr_wen2),
    .csr_waddr2     (csr_waddr2),
    .csr_wdata2     (csr_wdata2),
    .mem_rreq_valid (mem_rreq_valid),
    .mem_raddr      (mem_raddr),
    .mem_rfn        (mem_rfn),
    .mem_rres_valid (mem_rres_valid),
    .mem_rdata      (mem_rdata),
    .mem_wreq_valid (mem_wreq_valid),
    .mem_waddr      (mem_waddr),
    .mem_wdata      (mem_wdata),
    .mem_wfn        (mem_wfn),
    .mem_wres_valid (mem_wres_valid)
  );

  csr_regs u_csr (
    .clk    (clk),
    .reset  (reset),
    .raddr  (csr_raddr),
    .rdata  (csr_rdata),
    .wen1   (csr_wen1),
    .waddr1 (csr_waddr1),
    .wdata1 (csr_wdata1),
    .wen2   (csr_wen2),
    .waddr2 (csr_waddr2),
    .wdata2 (csr_wdata2)
  );

  data_mem u_dmem (
    .clk        (clk),
    .reset      (reset),
    .rreq_valid (mem_rreq_valid),
    .raddr      (mem_raddr),
    .rfn        (mem_rfn),
    .rres_valid (mem_rres_valid),
    .rdata      (mem_rdata),
    .wreq_valid (mem_wreq_valid),
    .waddr      (mem_waddr),
    .wdata      (mem_wdata),
    .wfn        (mem_wfn),
    .wres_valid (mem_wres_valid)
  );

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit
  import rv_isa_pkg::*;
  import rv_csr_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            in_valid,
  output logic            in_ready,
  input  logic [xlen-1:0] pc,
  input  op_class_e       opcode,
  input  logic [2:0]      funct,
  input  logic [4:0]      rd,
  input  logic [xlen-1:0] src1,
  input  logic [xlen-1:0] src2,
  input  logic [xlen-1:0] imm,
  input  logic [xlen-1:0] alu_a,
  input  logic [xlen-1:0] alu_b,
  input  alu_fn_e         alu_fn,
  input  logic            alu_alt,
  output logic [xlen-1:0] npc,
  output logic            gpr_wen,
  output logic [4:0]      gpr_waddr,
  output logic [xlen-1:0] gpr_wdata,
  output csr_addr_e       csr_raddr,
  input  logic [xlen-1:0] csr_rdata,
  output logic            csr_wen1,
  output csr_addr_e       csr_waddr1,
  output logic [xlen-1:0] csr_wdata1,
  output logic            csr_wen2,
  output csr_addr_e       csr_waddr2,
  output logic [xlen-1:0] csr_wdata2,
  output logic            mem_rreq_valid,
  output logic [xlen-1:0] mem_raddr,
  output mem_fn_e         mem_rfn,
  input  logic            mem_rres_valid,
  input  logic [xlen-1:0] mem_rdata,
  output logic            mem_wreq_valid,
  output logic [xlen-1:0] mem_waddr,
  output logic [xlen-1:0] mem_wdata,
  output mem_fn_e         mem_wfn,
  input  logic            mem_wres_valid
);

  typedef enum logic [1:0] {st_idle, st_load, st_store} state_e;

  state_e          state;
  logic [xlen-1:0] alu_val;
  logic            accept;
  logic            is_load, is_store, is_sys, is_ecall, is_mret, csr_jump;
  logic            wb_en, csr_we1;
  logic [xlen-1:0] wb_data;
  logic [xlen-1:0] csr_val;
  logic            br_taken;
  logic [xlen-1:0] npc_base, npc_inc, npc_sum;

  alu u_alu (
    .a   (alu_a),
    .b   (alu_b),
    .fn  (alu_fn),
    .alt (alu_alt),
    .val (alu_val)
  );

  assign accept   = in_valid & in_ready;
  assign is_load  = opcode == op_load;
  assign is_store = opcode == op_store;
  assign is_sys   = opcode == op_sys;
  assign is_ecall = is_sys && funct == 3'd0 && imm[11:0] == funct12_ecall;
  assign is_mret  = is_sys && funct == 3'd0 && imm[11:0] == funct12_mret;
  assign csr_jump = is_ecall | is_mret;

  always_comb begin
    if (is_ecall) begin
      csr_raddr = csr_mtvec; // trap vector
    end else if (is_mret) begin
      csr_raddr = csr_mepc;
    end else begin
      csr_raddr = csr_addr_e'(imm[11:0]);
    end
  end

  // bypass a CSR write that lands at the coming edge, port 2 first
  always_comb begin
    if (csr_wen2 && csr_waddr2 == csr_raddr) begin
      csr_val = csr_wdata2;
    end else if (csr_wen1 && csr_waddr1 == csr_raddr) begin
      csr_val = csr_wdata1;
    end else begin
      csr_val = csr_rdata;
    end
  end

  always_comb begin
    case (opcode)
      op_lui, op_auipc, op_jal, op_jalr,
      op_calri, op_calrr: wb_en = 1'b1;
      op_sys:             wb_en = |funct; // csr instructions only
      default:            wb_en = 1'b0;
    endcase
  end

  assign wb_data = is_sys ? csr_val : alu_val;
  assign csr_we1 = is_sys && (funct != 3'd0 || is_ecall);

  // branch compare result comes out of the ALU
  always_comb begin
    case (br_fn_e'(funct))
      br_beq:           br_taken = alu_val == '0;
      br_bne:           br_taken = alu_val != '0;
      br_blt, br_bltu:  br_taken = alu_val[0];
      br_bge, br_bgeu:  br_taken = ~alu_val[0];
      default:          br_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      op_jal, op_jalr: npc_inc = imm;
      op_branch:       npc_inc = br_taken ? imm : xlen'(4);
      op_sys:          npc_inc = csr_jump ? '0 : xlen'(4);
      default:         npc_inc = xlen'(4);
    endcase
  end

  assign npc_base = (opcode == op_jalr) ? src1 : (csr_jump ? csr_val : pc);
  assign npc_sum  = npc_base + npc_inc;
  assign npc      = {npc_sum[xlen-1:1], 1'b0};

  // requests go out in the accept cycle
  assign mem_rreq_valid = accept & is_load;
  assign mem_raddr      = alu_val;
  assign mem_rfn        = mem_fn_e'(funct);
  assign mem_wreq_valid = accept & is_store;
  assign mem_waddr      = alu_val;
  assign mem_wdata      = src2;
  assign mem_wfn        = mem_fn_e'(funct);

  assign csr_waddr2 = csr_mcause;
  assign csr_wdata2 = cause_ecall_m;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      in_ready <= 1'b1;
      gpr_wen  <= 1'b0;
      csr_wen1 <= 1'b0;
      csr_wen2 <= 1'b0;
    end else begin
      gpr_wen  <= 1'b0; // pulses by default
      csr_wen1 <= 1'b0;
      csr_wen2 <= 1'b0;
      case (state)
        st_idle: begin
          if (accept && is_load) begin
            state    <= st_load;
            in_ready <= 1'b0;
          end else if (accept && is_store) begin
            state    <= st_store;
            in_ready <= 1'b0;
          end else if (accept) begin
            gpr_wen  <= wb_en;
            csr_wen1 <= csr_we1;
            csr_wen2 <= is_ecall;
          end
        end
        st_load: begin
          if (mem_rres_valid) begin
            state    <= st_idle;
            in_ready <= 1'b1;
            gpr_wen  <= 1'b1;
          end
        end
        st_store: begin
          if (mem_wres_valid) begin
            state    <= st_idle;
            in_ready <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept && (wb_en || is_load)) begin
      gpr_waddr <= rd;
    end
    if (accept && wb_en) begin
      gpr_wdata <= wb_data;
    end else if (state == st_load && mem_rres_valid) begin
      gpr_wdata <= mem_rdata; // already lane extended
    end
    if (accept && csr_we1) begin
      csr_waddr1 <= is_ecall ? csr_mepc : csr_addr_e'(imm[11:0]);
      csr_wdata1 <= is_ecall ? pc : alu_val; // ecall saves its own pc
    end
  end

  a_ready_idle: assert property (@(posedge clk) disable iff (reset)
    in_ready |-> state == st_idle)
    else $error("in_ready high while a memory access is pending");

  a_wen_pulse: assert property (@(posedge clk) disable iff (reset)
    (gpr_wen || csr_wen1 || csr_wen2) && !accept |=> !(gpr_wen || csr_wen1 || csr_wen2))
    else $error("write enable held without a new instruction");

  a_rres_load: assert property (@(posedge clk) disable iff (reset)
    mem_rres_valid |-> state == st_load)
    else $error("read response outside a load");

endmodule

`default_nettype wire

//--- hdl/rv_csr_pkg.sv
`default_nettype none

package rv_csr_pkg;

  // machine mode CSRs that are implemented
  typedef enum logic [11:0] {
    csr_mstatus = 12'h300,
    csr_mtvec   = 12'h305,
    csr_mepc    = 12'h341,
    csr_mcause  = 12'h342
  } csr_addr_e;

  // exception cause codes
  localparam logic [31:0] cause_ecall_m = 32'd11;

  // reset values
  localparam logic [31:0] mstatus_reset = 32'h0000_1800; // mpp = machine
  localparam logic [31:0] mtvec_reset   = 32'h0000_0100;

endpackage

`default_nettype wire

//--- hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int xlen   = 32;
  localparam int xbytes = xlen / 8; // byte lanes per word

  // data memory geometry
  localparam int mem_words = 256;
  localparam int mem_aw    = 8;

  // system instruction immediates (funct3 == 0)
  localparam logic [11:0] funct12_ecall = 12'h000;
  localparam logic [11:0] funct12_mret  = 12'h302;

  // instruction bits 6:2
  typedef enum logic [4:0] {
    op_load   = 5'b00000,
    op_calri  = 5'b00100,
    op_auipc  = 5'b00101,
    op_store  = 5'b01000,
    op_calrr  = 5'b01100,
    op_lui    = 5'b01101,
    op_branch = 5'b11000,
    op_jalr   = 5'b11001,
    op_jal    = 5'b11011,
    op_sys    = 5'b11100
  } op_class_e;

  typedef enum logic [2:0] {
    alu_add  = 3'd0, // sub with alt
    alu_sll  = 3'd1,
    alu_slt  = 3'd2,
    alu_sltu = 3'd3,
    alu_xor  = 3'd4,
    alu_srl  = 3'd5, // sra with alt
    alu_or   = 3'd6,
    alu_and  = 3'd7
  } alu_fn_e;

  typedef enum logic [2:0] {
    br_beq  = 3'd0,
    br_bne  = 3'd1,
    br_blt  = 3'd4,
    br_bge  = 3'd5,
    br_bltu = 3'd6,
    br_bgeu = 3'd7
  } br_fn_e;

  typedef enum logic [2:0] {
    mem_b  = 3'd0,
    mem_h  = 3'd1,
    mem_w  = 3'd2,
    mem_bu = 3'd4,
    mem_hu = 3'd5
  } mem_fn_e;

endpackage

`default_nettype wire

//--- tests/exec_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exec_top_tb
  import rv_isa_pkg::*;
  import rv_csr_pkg::*;
();

  // instruction counts per test set the run limit
  localparam int n_alu  = 200;
  localparam int n_br   = 120;
  localparam int n_jump = 20;
  localparam int n_mem  = 200;
  localparam int n_csr  = 13;
  localparam int n_mix  = 200;
  localparam int n_total = n_alu + n_br + 2 * n_jump + mem_words + n_mem + n_csr + n_mix;
  localparam int cycle_limit = 20 * n_total + 200;

  logic            clk = 1'b0;
  logic            reset;
  logic            in_valid;
  logic            in_ready;
  logic [xlen-1:0] pc, src1, src2, imm, alu_a, alu_b;
  op_class_e       opcode;
  logic [2:0]      funct;
  logic [4:0]      rd;
  alu_fn_e         alu_fn;
  logic            alu_alt;
  logic [xlen-1:0] npc;
  logic            gpr_wen;
  logic [4:0]      gpr_waddr;
  logic [xlen-1:0] gpr_wdata;

  int cyc = 0;
  int checks = 0;
  int errors = 0;
  int issued = 0;
  int t_issued = 0;
  int t_errors = 0;

  // shadow state
  logic [xlen-1:0] smem [mem_words];
  logic [xlen-1:0] sh_mstatus, sh_mtvec, sh_mepc, sh_mcause;

  // expected register writes in issue order
  int              exp_cyc_q  [$];
  logic [4:0]      exp_addr_q [$];
  logic [xlen-1:0] exp_data_q [$];

  mem_fn_e   ld_fns [5]   = '{mem_b, mem_h, mem_w, mem_bu, mem_hu};
  br_fn_e    br_fns [6]   = '{br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
  csr_addr_e csr_list [4] = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause};

  exec_top DUT (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .pc        (pc),
    .opcode    (opcode),
    .funct     (funct),
    .rd        (rd),
    .src1      (src1),
    .src2      (src2),
    .imm       (imm),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_fn    (alu_fn),
    .alu_alt   (alu_alt),
    .npc       (npc),
    .gpr_wen   (gpr_wen),
    .gpr_waddr (gpr_waddr),
    .gpr_wdata (gpr_wdata)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cyc);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_eq(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                          input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s, got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  function automatic logic [xlen-1:0] sext12(input logic [11:0] v);
    return {{(xlen-12){v[11]}}, v};
  endfunction

  function automatic logic [xlen-1:0] alu_model(input logic [xlen-1:0] a, b,
                                                input alu_fn_e fn, input logic alt);
    int s;
    s = b[4:0];
    case (fn)
      alu_add:  return alt ? a - b : a + b;
      alu_sll:  return a << s;
      alu_slt:  return (a[31] != b[31]) ? xlen'(a[31]) : xlen'(a < b); // sign decides first
      alu_sltu: return xlen'(a < b);
      alu_xor:  return a ^ b;
      alu_srl:  return (a >> s) | ((alt && a[31]) ? ~({xlen{1'b1}} >> s) : '0);
      alu_or:   return a | b;
      default:  return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f, input logic [xlen-1:0] a, b);
    case (f)
      br_beq:  return a == b;
      br_bne:  return a != b;
      br_blt:  return $signed(a) < $signed(b);
      br_bge:  return $signed(a) >= $signed(b);
      br_bltu: return a < b;
      br_bgeu: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [xlen-1:0] load_value(input logic [xlen-1:0] addr,
                                                 input logic [2:0] f);
    logic [xlen-1:0] w;
    w = smem[addr[mem_aw+1:2]] >> (8 * addr[1:0]);
    case (f)
      mem_b:   return {{(xlen-8){w[7]}}, w[7:0]};
      mem_bu:  return {{(xlen-8){1'b0}}, w[7:0]};
      mem_h:   return {{(xlen-16){w[15]}}, w[15:0]};
      mem_hu:  return {{(xlen-16){1'b0}}, w[15:0]};
      default: return w;
    endcase
  endfunction

  function automatic logic [xlen-1:0] csr_read(input logic [11:0] a);
    case (a)
      csr_mstatus: return sh_mstatus;
      csr_mtvec:   return sh_mtvec;
      csr_mepc:    return sh_mepc;
      csr_mcause:  return sh_mcause;
      default:     return '0;
    endcase
  endfunction

  task automatic store_shadow(input logic [xlen-1:0] addr, data, input logic [2:0] f);
    logic [mem_aw-1:0] idx;
    idx = addr[mem_aw+1:2];
    case (f)
      mem_b:   smem[idx][8*addr[1:0] +: 8]  = data[7:0];
      mem_h:   smem[idx][8*addr[1:0] +: 16] = data[15:0];
      default: smem[idx] = data;
    endcase
  endtask

  task automatic csr_write_shadow(input logic [11:0] a, input logic [xlen-1:0] v);
    case (a)
      csr_mstatus: sh_mstatus = v;
      csr_mtvec:   sh_mtvec = v;
      csr_mepc:    sh_mepc = v;
      csr_mcause:  sh_mcause = v;
      default:     ;
    endcase
  endtask

  // expected outcome of the instruction currently offered
  function automatic void ref_exec(output logic [xlen-1:0] e_npc, output logic e_wen,
                                   output logic [4:0] e_waddr, output logic [xlen-1:0] e_wdata);
    logic [xlen-1:0] v;
    v = alu_model(alu_a, alu_b, alu_fn, alu_alt);
    e_npc = pc + 4;
    e_wen = 1'b0;
    e_waddr = rd;
    e_wdata = v;
    case (opcode)
      op_lui, op_auipc, op_calri, op_calrr: e_wen = 1'b1;
      op_jal: begin
        e_npc = pc + imm;
        e_wen = 1'b1;
        e_wdata = pc + 4; // link
      end
      op_jalr: begin
        e_npc = src1 + imm;
        e_wen = 1'b1;
        e_wdata = pc + 4;
      end
      op_branch: if (branch_taken(funct, src1, src2)) e_npc = pc + imm;
      op_load: begin
        e_wen = 1'b1;
        e_wdata = load_value(v, funct);
      end
      op_sys: begin
        if (funct != 3'd0) begin
          e_wen = 1'b1;
          e_wdata = csr_read(imm[11:0]); // old value
        end else if (imm[11:0] == funct12_ecall) begin
          e_npc = csr_read(csr_mtvec);
        end else if (imm[11:0] == funct12_mret) begin
          e_npc = csr_read(csr_mepc);
        end
      end
      default: ;
    endcase
    e_npc[0] = 1'b0;
  endfunction

  task automatic update_shadow();
    logic [xlen-1:0] v;
    v = alu_model(alu_a, alu_b, alu_fn, alu_alt);
    if (opcode == op_store) begin
      store_shadow(v, src2, funct);
    end else if (opcode == op_sys && funct != 3'd0) begin
      csr_write_shadow(imm[11:0], v);
    end else if (opcode == op_sys && imm[11:0] == funct12_ecall) begin
      sh_mepc = pc;
      sh_mcause = cause_ecall_m;
    end
  endtask

  // offer the current fields, wait for the handshake, queue the expected write
  task automatic issue();
    logic [xlen-1:0] e_npc, e_wdata;
    logic            e_wen;
    logic [4:0]      e_waddr;
    int              stalls;
    int              due;
    stalls = 0;
    in_valid = 1'b1;
    @(negedge clk);
    while (!in_ready) begin
      stalls++;
      @(negedge clk);
    end
    if (stalls > 0) note_failure("in_ready was low while no instruction was in flight");
    ref_exec(e_npc, e_wen, e_waddr, e_wdata);
    check_eq(npc, e_npc, "next pc");
    due = cyc + ((opcode == op_load) ? 2 : 1);
    update_shadow();
    issued++;
    @(posedge clk);
    if (e_wen) begin
      exp_cyc_q.push_back(due);
      exp_addr_q.push_back(e_waddr);
      exp_data_q.push_back(e_wdata);
    end
    #1;
    in_valid = 1'b0;
    if (opcode == op_load || opcode == op_store) begin
      @(negedge clk);
      check_eq(in_ready, 1'b0, "in_ready during memory access");
      @(negedge clk);
      check_eq(in_ready, 1'b1, "in_ready after memory access");
      @(posedge clk);
      #1;
    end
  endtask

  // register write pulses against the queue
  always @(negedge clk) begin
    if (!reset) begin
      if (gpr_wen) begin
        if (exp_cyc_q.size() == 0) begin
          note_failure("register write pulse with no instruction expecting one");
        end else begin
          if (exp_cyc_q[0] != cyc) note_failure("register write pulse in the wrong cycle");
          check_eq(gpr_waddr, exp_addr_q[0], "write address");
          check_eq(gpr_wdata, exp_data_q[0], "write data");
          void'(exp_cyc_q.pop_front());
          void'(exp_addr_q.pop_front());
          void'(exp_data_q.pop_front());
        end
      end else if (exp_cyc_q.size() > 0 && exp_cyc_q[0] <= cyc) begin
        note_failure("expected register write pulse did not arrive");
        void'(exp_cyc_q.pop_front());
        void'(exp_addr_q.pop_front());
        void'(exp_data_q.pop_front());
      end
    end
  end

  task automatic reset_dut();
    reset = 1'b1;
    in_valid = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    sh_mstatus = mstatus_reset;
    sh_mtvec = mtvec_reset;
    sh_mepc = '0;
    sh_mcause = '0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic finish_test(input string name);
    idle(4);
    if (exp_cyc_q.size() != 0) note_failure("register writes still outstanding at test end");
    exp_cyc_q.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
    $display("%s: %0d instructions, %0d errors", name, issued - t_issued, errors - t_errors);
    t_issued = issued;
    t_errors = errors;
  endtask

  task automatic randomize_fields();
    pc = $urandom & 32'hffff_fffc;
    rd = 5'($urandom);
    src1 = $urandom;
    src2 = $urandom;
    imm = sext12(12'($urandom));
  endtask

  task automatic set_ops(input op_class_e op, input logic [2:0] f,
                         input logic [xlen-1:0] a, b, input alu_fn_e fn, input logic alt);
    opcode = op;
    funct = f;
    alu_a = a;
    alu_b = b;
    alu_fn = fn;
    alu_alt = alt;
  endtask

  task automatic alu_instr(input op_class_e op, input alu_fn_e fn, input logic alt);
    randomize_fields();
    set_ops(op, 3'd0, src1, (op == op_calri) ? imm : src2, fn, alt);
    issue();
  endtask

  task automatic upper_instr(input op_class_e op);
    randomize_fields();
    imm = $urandom & 32'hffff_f000;
    set_ops(op, 3'd0, (op == op_lui) ? '0 : pc, imm, alu_add, 1'b0);
    issue();
  endtask

  // link value pc+4 comes through the ALU
  task automatic jump_instr(input op_class_e op);
    randomize_fields();
    set_ops(op, 3'd0, pc, xlen'(4), alu_add, 1'b0);
    issue();
  endtask

  // rel 0 equal, 1 less, 2 greater
  task automatic branch_instr(input br_fn_e bf, input int rel);
    logic [xlen-1:0] x, y, t;
    logic            lt;
    alu_fn_e         fn;
    logic            alt;
    randomize_fields();
    x = $urandom;
    y = (rel == 0) ? x : $urandom;
    if (rel != 0 && x == y) y = x + 1;
    lt = (bf == br_bltu || bf == br_bgeu) ? (x < y) : ($signed(x) < $signed(y));
    if ((rel == 1 && !lt) || (rel == 2 && lt)) begin
      t = x;
      x = y;
      y = t;
    end
    src1 = x;
    src2 = y;
    imm[0] = 1'b0;
    case (bf)
      br_beq, br_bne: begin
        fn = alu_add;
        alt = 1'b1; // subtract
      end
      br_blt, br_bge: begin
        fn = alu_slt;
        alt = 1'b0;
      end
      default: begin
        fn = alu_sltu;
        alt = 1'b0;
      end
    endcase
    set_ops(op_branch, bf, x, y, fn, alt);
    issue();
  endtask

  function automatic logic [xlen-1:0] rand_addr(input mem_fn_e f);
    logic [xlen-1:0] a;
    a = $urandom; // upper bits are ignored by the memory
    case (f)
      mem_w:         a[1:0] = 2'b00;
      mem_h, mem_hu: a[0] = 1'b0;
      default:       ;
    endcase
    return a;
  endfunction

  task automatic mem_instr(input op_class_e op, input mem_fn_e f, input logic [xlen-1:0] addr);
    randomize_fields();
    src1 = addr - imm;
    set_ops(op, f, src1, imm, alu_add, 1'b0);
    issue();
  endtask

  task automatic csr_instr(input logic [2:0] f, input csr_addr_e ca,
                           input logic [xlen-1:0] a, b, input alu_fn_e fn);
    randomize_fields();
    imm = {20'd0, ca};
    set_ops(op_sys, f, a, b, fn, 1'b0);
    issue();
  endtask

  task automatic sys_instr(input logic [11:0] code);
    randomize_fields();
    imm = {20'd0, code};
    set_ops(op_sys, 3'd0, src1, src2, alu_add, 1'b0);
    issue();
  endtask

  task automatic random_instr();
    mem_fn_e   f;
    csr_addr_e ca;
    case ($urandom_range(0, 10))
      0:  alu_instr(op_calri, alu_fn_e'($urandom_range(0, 7)), $urandom_range(0, 1));
      1:  alu_instr(op_calrr, alu_fn_e'($urandom_range(0, 7)), $urandom_range(0, 1));
      2:  upper_instr(op_lui);
      3:  upper_instr(op_auipc);
      4:  branch_instr(br_fns[$urandom_range(0, 5)], $urandom_range(0, 2));
      5:  jump_instr(op_jal);
      6:  jump_instr(op_jalr);
      7: begin
        f = ld_fns[$urandom_range(0, 4)];
        mem_instr(op_load, f, rand_addr(f));
      end
      8: begin
        f = ld_fns[$urandom_range(0, 2)]; // b, h, w only
        mem_instr(op_store, f, rand_addr(f));
      end
      9: begin
        ca = csr_list[$urandom_range(0, 3)];
        if ($urandom_range(0, 1)) csr_instr(3'd1, ca, $urandom, '0, alu_or);
        else csr_instr(3'd2, ca, csr_read(ca), $urandom, alu_or);
      end
      default: sys_instr($urandom_range(0, 1) ? funct12_ecall : funct12_mret);
    endcase
  endtask

  initial begin
    mem_fn_e         f;
    logic [xlen-1:0] a;
    logic [xlen-1:0] v;
    void'($urandom(32'h9edb_1993));
    reset = 1'b1;
    in_valid = 1'b0;
    pc = '0;
    opcode = op_calri;
    funct = 3'd0;
    rd = '0;
    src1 = '0;
    src2 = '0;
    imm = '0;
    alu_a = '0;
    alu_b = '0;
    alu_fn = alu_add;
    alu_alt = 1'b0;
    reset_dut();

    for (int i = 0; i < n_alu; i++) begin
      alu_instr(((i / 16) % 2) ? op_calrr : op_calri, alu_fn_e'(i % 8), (i / 8) % 2);
    end
    finish_test("test 1 alu writeback");

    for (int i = 0; i < n_br; i++) branch_instr(br_fns[i % 6], (i / 6) % 3);
    for (int i = 0; i < n_jump; i++) begin
      jump_instr(op_jal);
      jump_instr(op_jalr);
    end
    finish_test("test 2 control flow");

    for (int w = 0; w < mem_words; w++) begin
      a = $urandom;
      a[mem_aw+1:0] = {mem_aw'(w), 2'b00};
      mem_instr(op_store, mem_w, a); // fill every word first
    end
    for (int i = 0; i < n_mem; i++) begin
      if ($urandom_range(0, 1)) begin
        f = ld_fns[$urandom_range(0, 2)];
        mem_instr(op_store, f, rand_addr(f));
      end else begin
        f = ld_fns[$urandom_range(0, 4)];
        mem_instr(op_load, f, rand_addr(f));
      end
    end
    finish_test("test 3 memory");

    foreach (csr_list[i]) begin
      v = $urandom;
      csr_instr(3'd1, csr_list[i], v, '0, alu_or);
      csr_instr(3'd2, csr_list[i], csr_read(csr_list[i]), '0, alu_or); // reads back v
    end
    csr_instr(3'd1, csr_mtvec, mtvec_reset, '0, alu_or);
    sys_instr(funct12_ecall);
    csr_instr(3'd2, csr_mepc, csr_read(csr_mepc), '0, alu_or);
    csr_instr(3'd2, csr_mcause, csr_read(csr_mcause), '0, alu_or);
    sys_instr(funct12_mret);
    finish_test("test 4 csr");

    reset_dut();
    @(negedge clk);
    check_eq(in_ready, 1'b1, "in_ready after reset");
    check_eq(gpr_wen, 1'b0, "gpr_wen after reset");
    @(posedge clk);
    #1;
    for (int i = 0; i < n_mix; i++) begin
      random_instr();
      idle($urandom_range(0, 3));
    end
    finish_test("test 5 mixed traffic");

    $display("summary: %0d instructions, %0d checks, %0d errors", issued, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
